// ==== include/pipeline_cfg.svh ====
////////////////////
// Front end sizing
////////////////////

`ifndef PIPELINE_CFG_SVH
`define PIPELINE_CFG_SVH

// Architectural data and address width
`define XLEN 32

// One RV32I instruction word
`define INST_W 32

// Memory line returned per request
// Holds two instruction words
`define LINE_W 64

// Entries in the fetch to dispatch buffer
// Must stay a power of two so the pointers wrap on their own
`define IB_DEPTH 8

`endif

// ==== source/isa_pkg.sv ====
////////////////////
// RV32I types
////////////////////

`default_nettype none

`include "pipeline_cfg.svh"

package isa_pkg;

    // One raw instruction word
    typedef logic [`INST_W-1:0] inst_t;

    // Architectural register index, x0 to x31
    typedef logic [4:0] reg_idx_t;

    // Immediate after sign extension
    typedef logic [`XLEN-1:0] imm_t;

    // Coarse class of a decoded instruction
    typedef enum logic [3:0] {
        OP_ALU_REG = 4'h0,
        OP_ALU_IMM = 4'h1,
        OP_LOAD    = 4'h2,
        OP_STORE   = 4'h3,
        OP_BRANCH  = 4'h4,
        OP_JAL     = 4'h5,
        OP_JALR    = 4'h6,
        OP_LUI     = 4'h7,
        OP_AUIPC   = 4'h8,
        OP_SYSTEM  = 4'h9,
        OP_ILLEGAL = 4'hf
    } opclass_t;

    ////////////////////
    // Major opcodes, bits 6:0
    ////////////////////
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // WFI encoding, stops dispatch for good
    localparam inst_t WFI_WORD = 32'h10500073;

endpackage

`default_nettype wire

// ==== source/pipe_pkg.sv ====
////////////////////
// Pipeline types
////////////////////

`default_nettype none

`include "pipeline_cfg.svh"

package pipe_pkg;

    // Byte address into memory
    typedef logic [`XLEN-1:0] addr_t;

    // One full memory line
    typedef logic [`LINE_W-1:0] line_t;

    // Memory command, loads only on this port
    typedef enum logic [1:0] {
        BUS_NONE = 2'h0,
        BUS_LOAD = 2'h1
    } mem_cmd_t;

    // Status reported at the top
    typedef enum logic [3:0] {
        NO_ERROR      = 4'h0,
        ILLEGAL_INST  = 4'h2,
        HALTED_ON_WFI = 4'he
    } error_t;

    // Dispatch FSM
    typedef enum logic {
        DP_RUN    = 1'b0,
        DP_HALTED = 1'b1
    } dp_state_t;

    // Read or write index into the instruction buffer
    typedef logic [$clog2(`IB_DEPTH)-1:0] ib_ptr_t;

endpackage

`default_nettype wire

// ==== source/fetch_unit.sv ====
////////////////////
// Instruction fetch
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "pipeline_cfg.svh"

module fetch_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic     clock,
    input  logic     arst_n,
    input  logic     squash,
    input  addr_t    branch_pc,
    input  logic     ib_full,
    input  line_t    mem2proc_data,
    output mem_cmd_t proc2mem_command,
    output addr_t    proc2mem_addr,
    output logic     push,
    output inst_t    fetch_inst,
    output addr_t    fetch_pc
);

    // Current fetch address
    addr_t pc;

    ////////////////////
    // Memory request
    ////////////////////

    // Ask for a line only with room in the buffer
    // No request in the squash cycle, the PC is stale
    always_comb begin
        if (!ib_full && !squash) begin
            proc2mem_command = BUS_LOAD;
        end else begin
            proc2mem_command = BUS_NONE;
        end
    end

    // Line aligned address, low three bits dropped
    assign proc2mem_addr = {pc[`XLEN-1:3], 3'b000};

    // Memory answers this cycle, so a load is a push
    assign push = (proc2mem_command == BUS_LOAD);

    ////////////////////
    // Word select
    ////////////////////

    // PC bit 2 picks the upper word of the line
    always_comb begin
        if (pc[2]) begin
            fetch_inst = mem2proc_data[`LINE_W-1 -: `INST_W];
        end else begin
            fetch_inst = mem2proc_data[`INST_W-1:0];
        end
    end

    assign fetch_pc = pc;

    ////////////////////
    // PC register
    ////////////////////

    // Squash redirect wins over sequential advance
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (squash) begin
            pc <= branch_pc;
        end else if (push) begin
            pc <= pc + addr_t'(4);
        end
    end

endmodule

`default_nettype wire

// ==== source/insn_buffer.sv ====
////////////////////
// Instruction buffer
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "pipeline_cfg.svh"

module insn_buffer
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic  clock,
    input  logic  arst_n,
    input  logic  squash,
    input  logic  push,
    input  inst_t push_inst,
    input  addr_t push_pc,
    input  logic  pop,
    output logic  full,
    output logic  empty,
    output inst_t head_inst,
    output addr_t head_pc
);

    // Count needs one more bit than a pointer to reach IB_DEPTH
    localparam int CNT_W = $clog2(`IB_DEPTH) + 1;

    // Entry storage, instruction and its PC side by side
    inst_t inst_mem [`IB_DEPTH];
    addr_t pc_mem   [`IB_DEPTH];

    ib_ptr_t          wr_ptr;
    ib_ptr_t          rd_ptr;
    logic [CNT_W-1:0] count;

    ////////////////////
    // Status and head
    ////////////////////

    assign full  = (count == CNT_W'(`IB_DEPTH));
    assign empty = (count == '0);

    // Oldest entry, read straight from storage
    assign head_inst = inst_mem[rd_ptr];
    assign head_pc   = pc_mem[rd_ptr];

    ////////////////////
    // Storage write
    ////////////////////

    // Producer checks full, every push lands
    always_ff @(posedge clock) begin
        if (push) begin
            inst_mem[wr_ptr] <= push_inst;
            pc_mem[wr_ptr]   <= push_pc;
        end
    end

    ////////////////////
    // Pointers and count
    ////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (squash) begin
            // Flush everything fetched down the wrong path
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/dispatch_decode.sv ====
////////////////////
// Dispatch and decode
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "pipeline_cfg.svh"

module dispatch_decode
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic     clock,
    input  logic     arst_n,
    input  logic     squash,
    input  logic     dispatch_ready,
    input  logic     empty,
    input  inst_t    head_inst,
    input  addr_t    head_pc,
    output logic     pop,
    output logic     dp_valid,
    output addr_t    dp_pc,
    output inst_t    dp_inst,
    output opclass_t dp_opclass,
    output reg_idx_t dp_rd,
    output reg_idx_t dp_rs1,
    output reg_idx_t dp_rs2,
    output imm_t     dp_imm,
    output error_t   error_status
);

    dp_state_t state;

    // Decode results for the head entry
    opclass_t dec_class;
    imm_t     dec_imm;
    logic     dec_wfi;

    // Immediates of every format, one gets picked
    imm_t imm_i;
    imm_t imm_s;
    imm_t imm_b;
    imm_t imm_u;
    imm_t imm_j;

    // Head leaves only while running and downstream has room
    assign pop = !empty && dispatch_ready && (state == DP_RUN) && !squash;

    ////////////////////
    // Immediate formats
    ////////////////////

    assign imm_i = {{(`XLEN-12){head_inst[31]}}, head_inst[31:20]};
    assign imm_s = {{(`XLEN-12){head_inst[31]}}, head_inst[31:25], head_inst[11:7]};
    assign imm_b = {{(`XLEN-13){head_inst[31]}}, head_inst[31], head_inst[7],
                    head_inst[30:25], head_inst[11:8], 1'b0};
    assign imm_u = {head_inst[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){head_inst[31]}}, head_inst[31], head_inst[19:12],
                    head_inst[20], head_inst[30:21], 1'b0};

    assign dec_wfi = (head_inst == WFI_WORD);

    ////////////////////
    // Opcode decode
    ////////////////////

    always_comb begin
        dec_class = OP_ILLEGAL;
        dec_imm   = '0;
        case (head_inst[6:0])
            OPC_OP: begin
                // Register ops carry no immediate
                dec_class = OP_ALU_REG;
            end
            OPC_OP_IMM: begin
                dec_class = OP_ALU_IMM;
                dec_imm   = imm_i;
            end
            OPC_LOAD: begin
                dec_class = OP_LOAD;
                dec_imm   = imm_i;
            end
            OPC_STORE: begin
                dec_class = OP_STORE;
                dec_imm   = imm_s;
            end
            OPC_BRANCH: begin
                dec_class = OP_BRANCH;
                dec_imm   = imm_b;
            end
            OPC_JAL: begin
                dec_class = OP_JAL;
                dec_imm   = imm_j;
            end
            OPC_JALR: begin
                dec_class = OP_JALR;
                dec_imm   = imm_i;
            end
            OPC_LUI: begin
                dec_class = OP_LUI;
                dec_imm   = imm_u;
            end
            OPC_AUIPC: begin
                dec_class = OP_AUIPC;
                dec_imm   = imm_u;
            end
            OPC_SYSTEM: begin
                // CSR number or funct12 rides in the I field
                dec_class = OP_SYSTEM;
                dec_imm   = imm_i;
            end
            default: begin
                dec_class = OP_ILLEGAL;
                dec_imm   = '0;
            end
        endcase
    end

    ////////////////////
    // Output registers
    ////////////////////

    // Fields taken raw from the word, whatever the format
    always_ff @(posedge clock) begin
        if (pop) begin
            dp_pc      <= head_pc;
            dp_inst    <= head_inst;
            dp_opclass <= dec_class;
            dp_rd      <= head_inst[11:7];
            dp_rs1     <= head_inst[19:15];
            dp_rs2     <= head_inst[24:20];
            dp_imm     <= dec_imm;
        end
    end

    // Valid strobe, status and halt FSM
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            dp_valid     <= 1'b0;
            error_status <= NO_ERROR;
            state        <= DP_RUN;
        end else begin
            dp_valid <= pop;
            if (pop) begin
                if (dec_wfi) begin
                    // Sticky until reset
                    state        <= DP_HALTED;
                    error_status <= HALTED_ON_WFI;
                end else if (dec_class == OP_ILLEGAL) begin
                    error_status <= ILLEGAL_INST;
                end else begin
                    error_status <= NO_ERROR;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/pipeline_frontend.sv ====
////////////////////
// Front end top
////////////////////

`timescale 1ns/1ps
`default_nettype none

module pipeline_frontend
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic     clock,
    input  logic     arst_n,
    input  line_t    mem2proc_data,
    input  logic     squash,
    input  addr_t    branch_pc,
    input  logic     dispatch_ready,
    output mem_cmd_t proc2mem_command,
    output addr_t    proc2mem_addr,
    output logic     dp_valid,
    output addr_t    dp_pc,
    output inst_t    dp_inst,
    output opclass_t dp_opclass,
    output reg_idx_t dp_rd,
    output reg_idx_t dp_rs1,
    output reg_idx_t dp_rs2,
    output imm_t     dp_imm,
    output error_t   error_status
);

    ////////////////////
    // Stage wires
    ////////////////////

    // Fetch to buffer
    logic  push;
    inst_t fetch_inst;
    addr_t fetch_pc;

    // Buffer to dispatch
    logic  ib_full;
    logic  ib_empty;
    logic  pop;
    inst_t head_inst;
    addr_t head_pc;

    // Fetch, PC and memory request
    fetch_unit u_fetch_unit (
        .clock            (clock),
        .arst_n           (arst_n),
        .squash           (squash),
        .branch_pc        (branch_pc),
        .ib_full          (ib_full),
        .mem2proc_data    (mem2proc_data),
        .proc2mem_command (proc2mem_command),
        .proc2mem_addr    (proc2mem_addr),
        .push             (push),
        .fetch_inst       (fetch_inst),
        .fetch_pc         (fetch_pc)
    );

    // Decouples fetch from dispatch stalls
    insn_buffer u_insn_buffer (
        .clock     (clock),
        .arst_n    (arst_n),
        .squash    (squash),
        .push      (push),
        .push_inst (fetch_inst),
        .push_pc   (fetch_pc),
        .pop       (pop),
        .full      (ib_full),
        .empty     (ib_empty),
        .head_inst (head_inst),
        .head_pc   (head_pc)
    );

    // Decode and registered dispatch outputs
    dispatch_decode u_dispatch_decode (
        .clock          (clock),
        .arst_n         (arst_n),
        .squash         (squash),
        .dispatch_ready (dispatch_ready),
        .empty          (ib_empty),
        .head_inst      (head_inst),
        .head_pc        (head_pc),
        .pop            (pop),
        .dp_valid       (dp_valid),
        .dp_pc          (dp_pc),
        .dp_inst        (dp_inst),
        .dp_opclass     (dp_opclass),
        .dp_rd          (dp_rd),
        .dp_rs1         (dp_rs1),
        .dp_rs2         (dp_rs2),
        .dp_imm         (dp_imm),
        .error_status   (error_status)
    );

endmodule

`default_nettype wire

// ==== sim/pipeline_frontend_tb.sv ====
////////////////////
// Front end testbench
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "pipeline_cfg.svh"

module pipeline_frontend_tb
    import isa_pkg::*;
    import pipe_pkg::*;
;

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 5;
    localparam int MEM_WORDS   = 256;
    // Straight-line code at 0x000, halt sequence at 0x200
    localparam int MAIN_LEN    = 13;
    localparam int TABLE_LEN   = 16;
    localparam int HALT_HOLD   = 20;
    localparam int WATCHDOG_CYCLES = TABLE_LEN * 40;

    // One table row, expected decode next to the word
    typedef struct packed {
        addr_t    addr;
        inst_t    inst;
        opclass_t opclass;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        imm_t     imm;
        error_t   err;
    } entry_t;

    logic     clock;
    logic     arst_n;
    line_t    mem2proc_data;
    logic     squash;
    addr_t    branch_pc;
    logic     dispatch_ready;
    mem_cmd_t proc2mem_command;
    addr_t    proc2mem_addr;
    logic     dp_valid;
    addr_t    dp_pc;
    inst_t    dp_inst;
    opclass_t dp_opclass;
    reg_idx_t dp_rd;
    reg_idx_t dp_rs1;
    reg_idx_t dp_rs2;
    imm_t     dp_imm;
    error_t   error_status;

    inst_t  mem [MEM_WORDS];
    entry_t tbl [TABLE_LEN];
    int     n_entries   = 0;
    int     errors      = 0;
    int     base_errors = 0;
    int     tests_run   = 0;
    int     tests_bad   = 0;
    int     loads;

    pipeline_frontend pipeline_frontend_inst (
        .clock            (clock),
        .arst_n           (arst_n),
        .mem2proc_data    (mem2proc_data),
        .squash           (squash),
        .branch_pc        (branch_pc),
        .dispatch_ready   (dispatch_ready),
        .proc2mem_command (proc2mem_command),
        .proc2mem_addr    (proc2mem_addr),
        .dp_valid         (dp_valid),
        .dp_pc            (dp_pc),
        .dp_inst          (dp_inst),
        .dp_opclass       (dp_opclass),
        .dp_rd            (dp_rd),
        .dp_rs1           (dp_rs1),
        .dp_rs2           (dp_rs2),
        .dp_imm           (dp_imm),
        .error_status     (error_status)
    );

    ////////////////////
    // Clock and memory
    ////////////////////

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // Zero-latency memory, even word low and odd word high
    assign mem2proc_data = {mem[{proc2mem_addr[9:3], 1'b1}], mem[{proc2mem_addr[9:3], 1'b0}]};

    // Hard stop if dispatch never shows up
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("watchdog expired after %0d cycles, dispatch stopped making progress",
                 WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    ////////////////////
    // Table and helpers
    ////////////////////

    task automatic add_entry(input addr_t a, input inst_t w, input opclass_t c,
                             input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2,
                             input imm_t imm, input error_t err);
        tbl[n_entries] = '{a, w, c, rd, rs1, rs2, imm, err};
        n_entries++;
    endtask

    task automatic load_table();
        // addr, word, class, rd, rs1, rs2, imm, status after dispatch
        add_entry(32'h000, 32'h002081b3, OP_ALU_REG, 5'd3, 5'd1, 5'd2, 32'h0, NO_ERROR);
        add_entry(32'h004, 32'hfff30293, OP_ALU_IMM, 5'd5, 5'd6, 5'd31, 32'hffffffff, NO_ERROR);
        add_entry(32'h008, 32'h00812383, OP_LOAD, 5'd7, 5'd2, 5'd8, 32'h8, NO_ERROR);
        add_entry(32'h00c, 32'hfe952e23, OP_STORE, 5'd28, 5'd10, 5'd9, 32'hfffffffc, NO_ERROR);
        add_entry(32'h010, 32'h00208863, OP_BRANCH, 5'd16, 5'd1, 5'd2, 32'h10, NO_ERROR);
        add_entry(32'h014, 32'hfe419ce3, OP_BRANCH, 5'd25, 5'd3, 5'd4, 32'hfffffff8, NO_ERROR);
        add_entry(32'h018, 32'h001000ef, OP_JAL, 5'd1, 5'd0, 5'd1, 32'h800, NO_ERROR);
        add_entry(32'h01c, 32'h00008067, OP_JALR, 5'd0, 5'd1, 5'd0, 32'h0, NO_ERROR);
        add_entry(32'h020, 32'h12345537, OP_LUI, 5'd10, 5'd8, 5'd3, 32'h12345000, NO_ERROR);
        add_entry(32'h024, 32'hfffff597, OP_AUIPC, 5'd11, 5'd31, 5'd31, 32'hfffff000, NO_ERROR);
        add_entry(32'h028, 32'h7ff6c613, OP_ALU_IMM, 5'd12, 5'd13, 5'd31, 32'h7ff, NO_ERROR);
        add_entry(32'h02c, 32'h41078733, OP_ALU_REG, 5'd14, 5'd15, 5'd16, 32'h0, NO_ERROR);
        add_entry(32'h030, 32'h00000073, OP_SYSTEM, 5'd0, 5'd0, 5'd0, 32'h0, NO_ERROR);
        // Halt sequence, legal then unknown opcode then WFI
        add_entry(32'h200, 32'h00100093, OP_ALU_IMM, 5'd1, 5'd0, 5'd1, 32'h1, NO_ERROR);
        add_entry(32'h204, 32'hffffffff, OP_ILLEGAL, 5'd31, 5'd31, 5'd31, 32'h0, ILLEGAL_INST);
        add_entry(32'h208, 32'h10500073, OP_SYSTEM, 5'd0, 5'd0, 5'd5, 32'h105, HALTED_ON_WFI);
    endtask

    // LUI x0 carrying the word index, then table words on top
    task automatic fill_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {12'h000, 8'(i), 5'd0, 7'b0110111};
        end
        for (int j = 0; j < n_entries; j++) begin
            mem[tbl[j].addr[9:2]] = tbl[j].inst;
        end
    endtask

    function automatic int find_entry(input addr_t a);
        int idx;
        idx = -1;
        for (int j = 0; j < n_entries; j++) begin
            if (tbl[j].addr == a) idx = j;
        end
        return idx;
    endfunction

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_pc(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_decode(input opclass_t got_class, input reg_idx_t got_rd,
                                input reg_idx_t got_rs1, input reg_idx_t got_rs2,
                                input imm_t got_imm, input inst_t got_inst,
                                input entry_t exp);
        if (got_class !== exp.opclass || got_rd !== exp.rd || got_rs1 !== exp.rs1
                || got_rs2 !== exp.rs2 || got_imm !== exp.imm || got_inst !== exp.inst) begin
            errors++;
            $display("mismatch at %0t: pc %h got %h %s/%0d/%0d/%0d/%h, expected %h %s/%0d/%0d/%0d/%h",
                     $time, exp.addr, got_inst, got_class.name(), got_rd, got_rs1, got_rs2,
                     got_imm, exp.inst, exp.opclass.name(), exp.rd, exp.rs1, exp.rs2, exp.imm);
        end
    endtask

    task automatic check_error(input error_t got, input error_t exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: error_status %s, expected %s", $time, got.name(),
                     exp.name());
        end
    endtask

    task automatic check_command(input mem_cmd_t got, input mem_cmd_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: command %s %s, expected %s", $time, got.name(), what,
                     exp.name());
        end
    endtask

    ////////////////////
    // Stimulus tasks
    ////////////////////

    task automatic apply_reset(input logic ready);
        @(posedge clock);
        #DRIVE_DELAY;
        arst_n         = 1'b0;
        squash         = 1'b0;
        branch_pc      = '0;
        dispatch_ready = ready;
        repeat (4) @(posedge clock);
        #DRIVE_DELAY;
        arst_n = 1'b1;
    endtask

    // One cycle redirect
    task automatic pulse_squash(input addr_t target);
        @(posedge clock);
        #DRIVE_DELAY;
        squash    = 1'b1;
        branch_pc = target;
        @(posedge clock);
        #DRIVE_DELAY;
        squash = 1'b0;
    endtask

    // Scoreboard of expected PCs, popped on each dp_valid
    task automatic collect_dispatches(input addr_t start_pc, input int count,
                                      input logic random_ready);
        addr_t exp_q[$];
        addr_t exp_pc;
        int    idx;
        for (int k = 0; k < count; k++) begin
            exp_q.push_back(start_pc + addr_t'(4 * k));
        end
        while (exp_q.size() > 0) begin
            @(posedge clock);
            #DRIVE_DELAY;
            dispatch_ready = random_ready ? (($urandom % 2) != 0) : 1'b1;
            // Outputs settled mid-cycle
            @(negedge clock);
            if (dp_valid) begin
                exp_pc = exp_q.pop_front();
                check_pc(dp_pc, exp_pc, "dp_pc");
                idx = find_entry(exp_pc);
                if (idx < 0) begin
                    errors++;
                    $display("no table entry for pc %h at %0t", exp_pc, $time);
                end else begin
                    check_decode(dp_opclass, dp_rd, dp_rs1, dp_rs2, dp_imm, dp_inst,
                                 tbl[idx]);
                    check_error(error_status, tbl[idx].err);
                end
            end
        end
    endtask

    task automatic end_test(input string name);
        int n;
        n = errors - base_errors;
        tests_run++;
        if (n == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", tests_run, name, n);
        end
        base_errors = errors;
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        void'($urandom(32'hc5f2));
        arst_n         = 1'b0;
        squash         = 1'b0;
        branch_pc      = '0;
        dispatch_ready = 1'b0;
        load_table();
        fill_memory();

        apply_reset(1'b1);
        collect_dispatches('0, MAIN_LEN, 1'b0);
        end_test("in-order dispatch with ready high");

        apply_reset(1'b0);
        collect_dispatches('0, MAIN_LEN, 1'b1);
        end_test("in-order dispatch with random ready");

        // Reset state, then count loads until the buffer is full
        apply_reset(1'b0);
        @(negedge clock);
        check_command(proc2mem_command, BUS_LOAD, "after reset");
        check_error(error_status, NO_ERROR);
        if (dp_valid) begin
            errors++;
            $display("dp_valid high right after reset at %0t", $time);
        end
        loads = 0;
        while (proc2mem_command == BUS_LOAD && loads <= `IB_DEPTH) begin
            // Two words per line, so the line address steps every second load
            check_pc(proc2mem_addr, addr_t'(8 * (loads / 2)), "proc2mem_addr");
            loads++;
            @(negedge clock);
        end
        if (loads != `IB_DEPTH) begin
            errors++;
            $display("mismatch at %0t: %0d loads before stall, expected %0d", $time, loads,
                     `IB_DEPTH);
        end
        repeat (4) begin
            @(negedge clock);
            check_command(proc2mem_command, BUS_NONE, "with buffer full");
        end
        collect_dispatches('0, MAIN_LEN, 1'b0);
        check_command(proc2mem_command, BUS_LOAD, "after dispatch resumed");
        end_test("back-pressure stall and resume");

        // Jump ahead past the sequential fetch point
        apply_reset(1'b1);
        collect_dispatches('0, 3, 1'b0);
        pulse_squash(32'h020);
        @(negedge clock);
        if (dp_valid) begin
            errors++;
            $display("dp_valid high at %0t in the cycle after squash", $time);
        end
        collect_dispatches(32'h020, MAIN_LEN - 8, 1'b0);
        end_test("squash redirect");

        // Illegal word, then WFI halts dispatch for good
        apply_reset(1'b1);
        pulse_squash(32'h200);
        collect_dispatches(32'h200, 3, 1'b0);
        repeat (HALT_HOLD) begin
            @(negedge clock);
            if (dp_valid) begin
                errors++;
                $display("dp_valid high at %0t while halted on WFI", $time);
            end
            check_error(error_status, HALTED_ON_WFI);
        end
        end_test("illegal word and WFI halt");

        $display("%0d tests run, %0d with errors, %0d errors in total", tests_run, tests_bad,
                 errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== pipeline_frontend.f ====
+incdir+include
source/isa_pkg.sv
source/pipe_pkg.sv
source/fetch_unit.sv
source/insn_buffer.sv
source/dispatch_decode.sv
source/pipeline_frontend.sv
sim/pipeline_frontend_tb.sv

// ==== Makefile ====
# Verilator build and run of the pipeline front end

TOP = pipeline_frontend_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) \
		-f pipeline_frontend.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test completed successfully" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
